// File: verilog/lc3b_settings.svh
`ifndef LC3B_SETTINGS_SVH
`define LC3B_SETTINGS_SVH

// ----------------------------------------------------------------------
// Architectural sizes
// ----------------------------------------------------------------------

// Number of general purpose registers.
`define LC3B_REG_COUNT 8

// ----------------------------------------------------------------------
// Data memory
// ----------------------------------------------------------------------

`define LC3B_DMEM_WORDS 256
`define LC3B_DMEM_AW 8 // Word address width.

`endif

// File: verilog/lc3b_types.sv
`include "lc3b_settings.svh"

package lc3b_types;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [3:0] lc3b_opcode;
	typedef logic [1:0] lc3b_fwd_sel; // 0 regfile, 1 EX/MEM, 2 MEM/WB.
	typedef logic [`LC3B_DMEM_AW-1:0] lc3b_dmem_addr;

	// Supported opcodes.
	localparam lc3b_opcode op_add = 4'b0001;
	localparam lc3b_opcode op_and = 4'b0101;
	localparam lc3b_opcode op_not = 4'b1001;
	localparam lc3b_opcode op_ldr = 4'b0110;
	localparam lc3b_opcode op_str = 4'b0111;

	// ----------------------------------------------------------------------
	// Stage registers
	// ----------------------------------------------------------------------

	typedef struct packed {
		logic valid;
		lc3b_opcode opcode;
		lc3b_reg dest;
		lc3b_reg r_one;
		lc3b_reg r_two; // SR field for STR.
		logic uses_sr1;
		logic uses_sr2;
		logic use_imm;
		lc3b_word imm;
		logic regfile_write;
		logic mem_read;
		logic mem_write;
		lc3b_word rd_one;
		lc3b_word rd_two;
	} id_ex_t;

	typedef struct packed {
		logic valid;
		lc3b_reg dest;
		logic regfile_write;
		logic mem_read;
		logic mem_write;
		lc3b_word result; // ALU value or address.
		lc3b_word store_data;
	} ex_mem_t;

	typedef struct packed {
		logic valid;
		lc3b_reg dest;
		logic regfile_write;
		lc3b_word data;
	} mem_wb_t;

endpackage

// File: verilog/regfile.sv
`timescale 1ns/1ps
`include "lc3b_settings.svh"

module regfile import lc3b_types::*; (
	input logic clk,
	input logic rst_n,
	input lc3b_reg read_one,
	input lc3b_reg read_two,
	input logic write,
	input lc3b_reg write_dest,
	input lc3b_word write_data,
	output lc3b_word data_one,
	output lc3b_word data_two
);

	lc3b_word regs [`LC3B_REG_COUNT];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `LC3B_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (write) begin
			regs[write_dest] <= write_data;
		end
	end

	// Write-through so decode sees the value retiring this cycle.
	always_comb begin
		if (write && (write_dest == read_one)) begin
			data_one = write_data;
		end else begin
			data_one = regs[read_one];
		end
		if (write && (write_dest == read_two)) begin
			data_two = write_data;
		end else begin
			data_two = regs[read_two];
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) write |-> !$isunknown(write_data))
		else $error("regfile: unknown write data to r%0d", write_dest);

endmodule

// File: verilog/forwarding_unit.sv
`timescale 1ns/1ps

module forwarding_unit import lc3b_types::*; (
	input lc3b_reg id_ex_r_one,
	input lc3b_reg id_ex_r_two,
	input lc3b_reg ex_mem_r_dest,
	input lc3b_reg mem_wb_r_dest,
	input lc3b_reg if_id_r_one,
	input lc3b_reg if_id_r_two,
	input logic ex_mem_regfile_write,
	input logic mem_wb_regfile_write,
	input logic uses_sr1,
	input logic uses_sr2,
	input logic mem_read,
	output lc3b_fwd_sel forward_a,
	output lc3b_fwd_sel forward_b,
	output logic stall_forwarding,
	output logic flush_forwarding
);

	logic ex_forward_condition_a;
	logic ex_forward_condition_b;
	logic mem_forward_condition_a;
	logic mem_forward_condition_b;
	logic load_use_ex;
	logic load_use_id;

	// ----------------------------------------------------------------------
	// Operand forwarding
	// ----------------------------------------------------------------------

	assign ex_forward_condition_a = ex_mem_regfile_write && uses_sr1 &&
		(ex_mem_r_dest == id_ex_r_one);
	assign ex_forward_condition_b = ex_mem_regfile_write && uses_sr2 &&
		(ex_mem_r_dest == id_ex_r_two);

	// Older producer only when the newer one does not match.
	assign mem_forward_condition_a = mem_wb_regfile_write && uses_sr1 &&
		!ex_forward_condition_a && (mem_wb_r_dest == id_ex_r_one);
	assign mem_forward_condition_b = mem_wb_regfile_write && uses_sr2 &&
		!ex_forward_condition_b && (mem_wb_r_dest == id_ex_r_two);

	always_comb begin
		forward_a = 2'd0; // Register file.
		if (ex_forward_condition_a) begin
			forward_a = 2'd1;
		end else if (mem_forward_condition_a) begin
			forward_a = 2'd2;
		end
	end

	always_comb begin
		forward_b = 2'd0;
		if (ex_forward_condition_b) begin
			forward_b = 2'd1;
		end else if (mem_forward_condition_b) begin
			forward_b = 2'd2;
		end
	end

	// ----------------------------------------------------------------------
	// Load-use detection
	// ----------------------------------------------------------------------

	// Load data is not ready until the load reaches MEM/WB.
	assign load_use_ex = mem_read && (ex_forward_condition_a || ex_forward_condition_b);

	// Decode check ignores the uses flags.
	assign load_use_id = mem_read && ex_mem_regfile_write &&
		((ex_mem_r_dest == if_id_r_one) || (ex_mem_r_dest == if_id_r_two));

	assign stall_forwarding = load_use_ex || load_use_id;
	assign flush_forwarding = load_use_ex || load_use_id;

	always_comb begin
		if (stall_forwarding) begin
			assert (mem_read)
				else $error("forwarding_unit: stall without a load in EX/MEM");
		end
	end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu import lc3b_types::*; (
	input id_ex_t id_ex,
	input lc3b_fwd_sel forward_a,
	input lc3b_fwd_sel forward_b,
	input lc3b_word ex_mem_result,
	input lc3b_word mem_wb_data,
	output lc3b_word result,
	output lc3b_word store_data
);

	lc3b_word operand_a;
	lc3b_word fwd_b;
	lc3b_word operand_b;

	// Source selection.
	always_comb begin
		case (forward_a)
			2'd1: operand_a = ex_mem_result;
			2'd2: operand_a = mem_wb_data;
			default: operand_a = id_ex.rd_one;
		endcase
		case (forward_b)
			2'd1: fwd_b = ex_mem_result;
			2'd2: fwd_b = mem_wb_data;
			default: fwd_b = id_ex.rd_two;
		endcase
	end

	assign operand_b = id_ex.use_imm ? id_ex.imm : fwd_b;

	always_comb begin
		case (id_ex.opcode)
			op_add: result = operand_a + operand_b;
			op_and: result = operand_a & operand_b;
			op_not: result = ~operand_a;
			op_ldr,
			op_str: result = operand_a + operand_b; // Base plus offset.
			default: result = '0;
		endcase
	end

	// STR source register travels as r_two.
	assign store_data = fwd_b;

endmodule

// File: verilog/data_memory.sv
`timescale 1ns/1ps
`include "lc3b_settings.svh"

module data_memory import lc3b_types::*; (
	input logic clk,
	input lc3b_dmem_addr addr,
	input logic write,
	input lc3b_word write_data,
	output lc3b_word read_data
);

	// ----------------------------------------------------------------------
	// Storage
	// ----------------------------------------------------------------------

	lc3b_word mem [`LC3B_DMEM_WORDS];

	// Read is combinational so a load finishes in the memory stage.
	assign read_data = mem[addr];

	always_ff @(posedge clk) begin
		if (write) begin
			mem[addr] <= write_data;
		end
	end

	// ----------------------------------------------------------------------
	// Checks
	// ----------------------------------------------------------------------

	assert property (@(posedge clk) write |-> !$isunknown(addr))
		else $error("data_memory: store to unknown address");

endmodule

// File: verilog/lc3b_pipeline.sv
`timescale 1ns/1ps

module lc3b_pipeline import lc3b_types::*; (
	input logic clk,
	input logic rst_n,
	input lc3b_word instr,
	input logic instr_valid,
	output logic instr_ready,
	output logic wb_valid,
	output lc3b_reg wb_dest,
	output lc3b_word wb_data
);

	logic if_id_valid;
	lc3b_word if_id_instr;
	id_ex_t id_ex;
	ex_mem_t ex_mem;
	mem_wb_t mem_wb;

	lc3b_opcode opcode;
	lc3b_reg src_one;
	lc3b_reg src_two;
	lc3b_word rf_data_one;
	lc3b_word rf_data_two;
	id_ex_t decoded;
	lc3b_fwd_sel forward_a;
	lc3b_fwd_sel forward_b;
	logic stall_forwarding;
	logic flush_forwarding;
	lc3b_word alu_result;
	lc3b_word alu_store_data;
	ex_mem_t ex_mem_next;
	lc3b_word mem_read_data;
	lc3b_word wb_value;

	// ----------------------------------------------------------------------
	// Decode
	// ----------------------------------------------------------------------

	assign opcode = if_id_instr[15:12];
	assign src_one = if_id_instr[8:6];
	assign src_two = (opcode == op_str) ? if_id_instr[11:9] : if_id_instr[2:0];

	always_comb begin
		decoded = '0;
		decoded.opcode = opcode;
		decoded.dest = if_id_instr[11:9];
		decoded.r_one = src_one;
		decoded.r_two = src_two;
		decoded.rd_one = rf_data_one;
		decoded.rd_two = rf_data_two;
		if (if_id_valid) begin
			case (opcode)
				op_add,
				op_and: begin
					decoded.valid = 1'b1;
					decoded.uses_sr1 = 1'b1;
					decoded.uses_sr2 = !if_id_instr[5];
					decoded.use_imm = if_id_instr[5];
					decoded.imm = {{11{if_id_instr[4]}}, if_id_instr[4:0]};
					decoded.regfile_write = 1'b1;
				end
				op_not: begin
					decoded.valid = 1'b1;
					decoded.uses_sr1 = 1'b1;
					decoded.regfile_write = 1'b1;
				end
				op_ldr,
				op_str: begin
					decoded.valid = 1'b1;
					decoded.uses_sr1 = 1'b1;
					decoded.uses_sr2 = (opcode == op_str);
					decoded.use_imm = 1'b1;
					decoded.imm = {{9{if_id_instr[5]}}, if_id_instr[5:0], 1'b0};
					decoded.regfile_write = (opcode == op_ldr);
					decoded.mem_read = (opcode == op_ldr);
					decoded.mem_write = (opcode == op_str);
				end
				default: ; // Zero word and unsupported opcodes.
			endcase
		end
	end

	regfile regfile0 (
		.clk(clk),
		.rst_n(rst_n),
		.read_one(src_one),
		.read_two(src_two),
		.write(wb_valid),
		.write_dest(mem_wb.dest),
		.write_data(mem_wb.data),
		.data_one(rf_data_one),
		.data_two(rf_data_two)
	);

	// ----------------------------------------------------------------------
	// Execute
	// ----------------------------------------------------------------------

	forwarding_unit forwarding0 (
		.id_ex_r_one(id_ex.r_one),
		.id_ex_r_two(id_ex.r_two),
		.ex_mem_r_dest(ex_mem.dest),
		.mem_wb_r_dest(mem_wb.dest),
		.if_id_r_one(src_one),
		.if_id_r_two(src_two),
		.ex_mem_regfile_write(ex_mem.regfile_write),
		.mem_wb_regfile_write(mem_wb.regfile_write),
		.uses_sr1(id_ex.uses_sr1),
		.uses_sr2(id_ex.uses_sr2),
		.mem_read(ex_mem.mem_read),
		.forward_a(forward_a),
		.forward_b(forward_b),
		.stall_forwarding(stall_forwarding),
		.flush_forwarding(flush_forwarding)
	);

	alu alu0 (
		.id_ex(id_ex),
		.forward_a(forward_a),
		.forward_b(forward_b),
		.ex_mem_result(ex_mem.result),
		.mem_wb_data(mem_wb.data),
		.result(alu_result),
		.store_data(alu_store_data)
	);

	always_comb begin
		ex_mem_next.valid = id_ex.valid;
		ex_mem_next.dest = id_ex.dest;
		ex_mem_next.regfile_write = id_ex.regfile_write;
		ex_mem_next.mem_read = id_ex.mem_read;
		ex_mem_next.mem_write = id_ex.mem_write;
		ex_mem_next.result = alu_result;
		ex_mem_next.store_data = alu_store_data;
	end

	// ----------------------------------------------------------------------
	// Memory and writeback
	// ----------------------------------------------------------------------

	data_memory dmem0 (
		.clk(clk),
		.addr(ex_mem.result[8:1]), // Word address.
		.write(ex_mem.mem_write),
		.write_data(ex_mem.store_data),
		.read_data(mem_read_data)
	);

	assign wb_value = ex_mem.mem_read ? mem_read_data : ex_mem.result;

	assign instr_ready = !stall_forwarding;
	assign wb_valid = mem_wb.valid && mem_wb.regfile_write;
	assign wb_dest = mem_wb.dest;
	assign wb_data = mem_wb.data;

	// ----------------------------------------------------------------------
	// Stage registers
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			if_id_valid <= 1'b0;
			if_id_instr <= '0;
			id_ex <= '0;
		end else if (!stall_forwarding) begin
			if_id_valid <= instr_valid;
			if_id_instr <= instr_valid ? instr : '0;
			id_ex <= decoded;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem <= '0;
			mem_wb <= '0;
		end else begin
			if (flush_forwarding) begin
				ex_mem <= '0; // Bubble behind the load.
			end else begin
				ex_mem <= ex_mem_next;
			end
			mem_wb.valid <= ex_mem.valid;
			mem_wb.dest <= ex_mem.dest;
			mem_wb.regfile_write <= ex_mem.regfile_write;
			mem_wb.data <= wb_value;
		end
	end

endmodule

// File: verification/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Columns are instruction word, writes flag, destination, data, and
// whether instr_ready drops while this word is presented.
typedef struct packed {
	lc3b_word instr;
	logic writes;
	lc3b_reg dest;
	lc3b_word data;
	logic stall;
} program_entry_t;

localparam int program_len = 25;

localparam program_entry_t program_table [program_len] = '{
	// Dependent chains.
	{16'h1225, 1'b1, 3'd1, 16'h0005, 1'b0}, // ADD R1, R0, #5
	{16'h1463, 1'b1, 3'd2, 16'h0008, 1'b0}, // ADD R2, R1, #3
	{16'h1681, 1'b1, 3'd3, 16'h000d, 1'b0}, // ADD R3, R2, R1
	{16'h58e7, 1'b1, 3'd4, 16'h0005, 1'b0}, // AND R4, R3, #7
	{16'h5b03, 1'b1, 3'd5, 16'h0005, 1'b0}, // AND R5, R4, R3
	// Newer producer wins, then two back and three back.
	{16'h1261, 1'b1, 3'd1, 16'h0006, 1'b0}, // ADD R1, R1, #1
	{16'h1262, 1'b1, 3'd1, 16'h0008, 1'b0}, // ADD R1, R1, #2
	{16'h1c40, 1'b1, 3'd6, 16'h0008, 1'b0}, // ADD R6, R1, R0
	{16'h143f, 1'b1, 3'd2, 16'hffff, 1'b0}, // ADD R2, R0, #-1
	{16'h1e29, 1'b1, 3'd7, 16'h0009, 1'b0}, // ADD R7, R0, #9
	{16'h16a1, 1'b1, 3'd3, 16'h0000, 1'b0}, // ADD R3, R2, #1
	{16'h19c2, 1'b1, 3'd4, 16'h0008, 1'b0}, // ADD R4, R7, R2
	// ------------------------------------------------------------------
	// Store, load, use
	// ------------------------------------------------------------------
	{16'h7804, 1'b0, 3'd0, 16'h0000, 1'b0}, // STR R4, R0, #4
	{16'h6a04, 1'b1, 3'd5, 16'h0008, 1'b0}, // LDR R5, R0, #4
	{16'h1d41, 1'b1, 3'd6, 16'h0010, 1'b0}, // ADD R6, R5, R1
	{16'h9fbf, 1'b1, 3'd7, 16'hffef, 1'b0}, // NOT R7, R6
	{16'h0000, 1'b0, 3'd0, 16'h0000, 1'b1}, // Held during the load-use stall.
	{16'h7e05, 1'b0, 3'd0, 16'h0000, 1'b0}, // STR R7, R0, #5
	{16'h0000, 1'b0, 3'd0, 16'h0000, 1'b0},
	{16'h57ff, 1'b1, 3'd3, 16'hffef, 1'b0}, // AND R3, R7, #-1
	{16'h6405, 1'b1, 3'd2, 16'hffef, 1'b0}, // LDR R2, R0, #5
	{16'h0000, 1'b0, 3'd0, 16'h0000, 1'b0},
	{16'h12a1, 1'b1, 3'd1, 16'hfff0, 1'b0}, // ADD R1, R2, #1
	{16'h987f, 1'b1, 3'd4, 16'h000f, 1'b1}, // NOT R4, R1
	{16'h1b03, 1'b1, 3'd5, 16'hfffe, 1'b0}  // ADD R5, R4, R3
};

`endif

// File: verification/tb_lc3b_pipeline.sv
`timescale 1ns/1ps

module tb_lc3b_pipeline import lc3b_types::*; ();

	typedef struct packed {
		lc3b_reg dest;
		lc3b_word data;
	} wb_expect_t;

	`include "tb_program.svh"

	localparam int random_count = 40;
	localparam int cycle_limit = 2 * (program_len + random_count) + 20;

	logic clk;
	logic rst_n;
	lc3b_word instr;
	logic instr_valid;
	logic instr_ready;
	logic wb_valid;
	lc3b_reg wb_dest;
	lc3b_word wb_data;

	lc3b_word model_regs [8];
	wb_expect_t expect_q [$];
	wb_expect_t expect_front;
	logic [31:0] lcg_state;
	int cycle_count;

	lc3b_pipeline dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.instr(instr),
		.instr_valid(instr_valid),
		.instr_ready(instr_ready),
		.wb_valid(wb_valid),
		.wb_dest(wb_dest),
		.wb_data(wb_data)
	);

	always #20 clk = ~clk;

	// ----------------------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------------------

	task automatic check_value(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		if (actual !== expected) begin
			$display("mismatch %s: got %h expected %h", name, actual, expected);
			$display("FAIL: see errors above");
			$fatal(1, "value check failed");
		end
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// ADD, AND or NOT with random fields.
	function automatic lc3b_word random_alu_instr();
		logic [31:0] r;
		r = lcg_next();
		case (r[31:30])
			2'd2: return {op_and, r[29:27], r[26:24], r[15], r[15] ? r[20:16] : {2'b00, r[23:21]}};
			2'd3: return {op_not, r[29:27], r[26:24], 6'b111111};
			default: return {op_add, r[29:27], r[26:24], r[15], r[15] ? r[20:16] : {2'b00, r[23:21]}};
		endcase
	endfunction

	function automatic lc3b_word alu_reference(input lc3b_word word);
		lc3b_word a;
		lc3b_word b;
		a = model_regs[word[8:6]];
		b = word[5] ? {{11{word[4]}}, word[4:0]} : model_regs[word[2:0]];
		case (word[15:12])
			op_add: return a + b;
			op_and: return a & b;
			op_not: return ~a;
			default: return '0;
		endcase
	endfunction

	// Holds the word until accepted and counts the stall cycles.
	task automatic apply_instruction(input lc3b_word word, input logic writes,
		input lc3b_reg dest, input lc3b_word data, input logic stall_expected);
		int stall_cycles;
		wb_expect_t entry;
		entry.dest = dest;
		entry.data = data;
		if (writes) begin
			expect_q.push_back(entry);
			model_regs[dest] = data;
		end
		instr = word;
		instr_valid = 1'b1;
		stall_cycles = 0;
		@(negedge clk);
		while (!instr_ready) begin
			stall_cycles++;
			@(negedge clk);
		end
		@(posedge clk);
		#2;
		check_value("instr_ready low cycles", 16'(stall_cycles), stall_expected ? 16'd1 : 16'd0);
	endtask

	// ----------------------------------------------------------------------
	// Writeback monitor and timeout
	// ----------------------------------------------------------------------

	always @(negedge clk) begin
		if (rst_n && wb_valid) begin
			if (expect_q.size() == 0) begin
				$display("writeback to r%0d with data %h when none was expected", wb_dest, wb_data);
				$display("FAIL: see errors above");
				$fatal(1, "unexpected writeback");
			end else begin
				expect_front = expect_q.pop_front();
				check_value("wb_dest", 16'(wb_dest), 16'(expect_front.dest));
				check_value("wb_data", wb_data, expect_front.data);
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("run did not finish within %0d cycles", cycle_limit);
			$display("FAIL: see errors above");
			$fatal(1, "timeout");
		end
	end

	// ----------------------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------------------

	initial begin
		lc3b_word word;
		lc3b_word result;
		clk = 1'b0;
		rst_n = 1'b0;
		instr = '0;
		instr_valid = 1'b0;
		cycle_count = 0;
		lcg_state = 32'h115ae70e;
		for (int r = 0; r < 8; r++) begin
			model_regs[r] = '0;
		end
		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(negedge clk);
		check_value("instr_ready", 16'(instr_ready), 16'd1);
		check_value("wb_valid", 16'(wb_valid), 16'd0);
		@(posedge clk);
		#2;

		for (int i = 0; i < program_len; i++) begin
			apply_instruction(program_table[i].instr, program_table[i].writes,
				program_table[i].dest, program_table[i].data, program_table[i].stall);
		end

		for (int n = 0; n < random_count; n++) begin
			word = random_alu_instr();
			result = alu_reference(word);
			apply_instruction(word, 1'b1, word[11:9], result, 1'b0);
		end

		instr_valid = 1'b0;
		instr = '0;
		while (expect_q.size() != 0) begin
			@(negedge clk);
		end
		repeat (4) @(negedge clk); // Room for a stray writeback.
		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: all.f
+incdir+verilog
+incdir+verification
verilog/lc3b_types.sv
verilog/regfile.sv
verilog/forwarding_unit.sv
verilog/alu.sv
verilog/data_memory.sv
verilog/lc3b_pipeline.sv
verification/tb_lc3b_pipeline.sv

// File: Makefile
# Verilator build of the LC-3b pipeline testbench.

OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert \
		--top-module tb_lc3b_pipeline \
		-f all.f \
		-Mdir $(OBJ_DIR) -o sim

run: compile
	./$(OBJ_DIR)/sim

clean:
	rm -rf $(OBJ_DIR)
